// ==== project.f ====
source/scan_pkg.sv
source/test_mode_select.sv
source/pixel_packer.sv
source/channel_dma_writer.sv
source/dma_control.sv
source/sdram_write_arbiter.sv
source/scan_top.sv
verification/scan_assert.sv
verification/scan_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= scan_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/scan_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_tb;

    import scan_pkg::*;

    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 300;      // cycles allowed for a batch of writes
    localparam int SETUP_CYCLES = 40;
    localparam int STROBE_TOTAL = 8 + 8 + 24 + 48;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * STROBE_TOTAL
                                  + 5 * (SETUP_CYCLES + WAIT_LIMIT);
    localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;     // twice the budget

    localparam int WAIT_LOW    = 0;
    localparam int WAIT_RANDOM = 1;
    localparam int WAIT_HIGH   = 2;

    logic           w_bus_clk;
    logic           w_adc_rst;
    logic [3:0]     sw;
    sample_t        adc_data_0;
    sample_t        adc_data_1;
    sample_t        adc_data_2;
    logic           sample_strobe;
    logic           dma_on;
    sdram_addr_t    dma_start_address;
    sdram_addr_t    dma_buf_size;
    logic           sdram_waitrequest;
    beat_t          sdram_writedata;
    sdram_addr_t    sdram_address;
    logic           sdram_write;
    logic           fifo_overflow;
    done_cnt_t      dma_done_cnt;

    int             seed;
    int             wait_mode;
    int             strobe_cnt;         // strobes since reset, ramp reference
    int             err_cnt;
    int             test_cnt;
    int             fail_cnt;
    int             accept_cnt;
    sdram_addr_t    log_addr [int];     // accepted writes by acceptance order
    beat_t          log_data [int];
    beat_t          exp_beat [int];     // key is channel * 64 + beat number
    int             exp_cnt  [3];

    scan_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut_i
    (
        .w_bus_clk         ( w_bus_clk         ),
        .w_adc_rst         ( w_adc_rst         ),
        .sw                ( sw                ),
        .adc_data_0        ( adc_data_0        ),
        .adc_data_1        ( adc_data_1        ),
        .adc_data_2        ( adc_data_2        ),
        .sample_strobe     ( sample_strobe     ),
        .dma_on            ( dma_on            ),
        .dma_start_address ( dma_start_address ),
        .dma_buf_size      ( dma_buf_size      ),
        .sdram_waitrequest ( sdram_waitrequest ),
        .sdram_writedata   ( sdram_writedata   ),
        .sdram_address     ( sdram_address     ),
        .sdram_write       ( sdram_write       ),
        .fifo_overflow     ( fifo_overflow     ),
        .dma_done_cnt      ( dma_done_cnt      )
    );

    initial
    begin
        w_bus_clk = 1'b0;
        forever #(CLK_PERIOD / 2) w_bus_clk = ~w_bus_clk;
    end

    //////////////////////////////
    // sdram model

    initial
    begin
        sdram_waitrequest = 1'b0;
        forever
        begin
            @(posedge w_bus_clk);
            #2;
            case (wait_mode)
                WAIT_RANDOM: sdram_waitrequest = $random(seed) & 1;
                WAIT_HIGH:   sdram_waitrequest = 1'b1;
                default:     sdram_waitrequest = 1'b0;
            endcase
        end
    end

    always @(posedge w_bus_clk)
    begin
        if (sdram_write && !sdram_waitrequest)
        begin
            log_addr[accept_cnt] = sdram_address;
            log_data[accept_cnt] = sdram_writedata;
            accept_cnt = accept_cnt + 1;
        end
    end

    //////////////////////////////
    // helpers

    task automatic next_cycle();
        @(posedge w_bus_clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0t %s: expected %0h got %0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before)
            $display("%s: pass", name);
        else
        begin
            $display("%s: fail with %0d errors", name, err_cnt - err_before);
            fail_cnt++;
        end
    endtask

    task automatic set_mode(input int ch, input test_mode_e mode);
        sw = {2'(ch), mode};
        repeat (3) next_cycle();
        sw = 4'b1100;       // hold all modes
        repeat (2) next_cycle();
    endtask

    task automatic configure(input int start, input int size, input int mode);
        dma_on            = 1'b0;     // flush, ring index back to 0
        dma_start_address = sdram_addr_t'(start);
        dma_buf_size      = sdram_addr_t'(size);
        wait_mode         = mode;
        repeat (3) next_cycle();
        dma_on = 1'b1;
        next_cycle();
        accept_cnt = 0;
        log_addr.delete();
        log_data.delete();
        exp_beat.delete();
        for (int g = 0; g < 3; g++)
            exp_cnt[g] = 0;
    endtask

    // value a lane should carry for the source a channel is in
    function automatic sample_t expected_sample(input test_mode_e mode, input sample_t live);
        case (mode)
            mode_ramp:      return sample_t'(strobe_cnt);
            mode_pattern_a: return 12'hAAA;
            mode_pattern_b: return 12'h555;
            default:        return live;
        endcase
    endfunction

    task automatic send_strobe(input sample_t d0, input sample_t d1, input sample_t d2);
        adc_data_0    = d0;
        adc_data_1    = d1;
        adc_data_2    = d2;
        sample_strobe = 1'b1;
        next_cycle();
        sample_strobe = 1'b0;
        strobe_cnt++;
        next_cycle();
    endtask

    task automatic send_beat(input test_mode_e m0, input test_mode_e m1, input test_mode_e m2);
        test_mode_e mode [3];
        sample_t    live [3];
        beat_t      exp  [3];
        mode[0] = m0;
        mode[1] = m1;
        mode[2] = m2;
        for (int lane = 0; lane < 8; lane++)
        begin
            for (int g = 0; g < 3; g++)
            begin
                live[g] = sample_t'($random(seed));
                exp[g][lane*16 +: 16] = {4'h0, expected_sample(mode[g], live[g])};
            end
            send_strobe(live[0], live[1], live[2]);
        end
        for (int g = 0; g < 3; g++)
        begin
            exp_beat[g*64 + exp_cnt[g]] = exp[g];
            exp_cnt[g]++;
        end
    endtask

    task automatic wait_writes(input int count);
        int cycles;
        cycles = 0;
        while (accept_cnt < count && cycles < WAIT_LIMIT)
        begin
            next_cycle();
            cycles++;
        end
        assert (accept_cnt >= count)
        else
        begin
            $display("%0t: timed out with %0d of %0d sdram writes accepted", $time,
                     accept_cnt, count);
            err_cnt++;
        end
    endtask

    // writes inside channel g's region, in acceptance order, against the expected beats
    task automatic check_channel(input int g, input int start, input int size, input int count);
        int base;
        int k;
        base = start + size * g;
        k    = 0;
        for (int i = 0; i < accept_cnt; i++)
        begin
            if (int'(log_addr[i]) >= base && int'(log_addr[i]) < base + size)
            begin
                check_value("sdram_address", log_addr[i], base + (k % size));
                if (k < count)
                    check_value("sdram_writedata", log_data[i], exp_beat[g*64 + k]);
                k++;
            end
        end
        assert (k == count)
        else
        begin
            $display("channel %0d wrote %0d beats into its region instead of %0d", g, k, count);
            err_cnt++;
        end
    endtask

    //////////////////////////////
    // tests

    task automatic test_reset_state();
        int err_before;
        err_before = err_cnt;
        check_value("sdram_write", sdram_write, 1'b0);
        check_value("fifo_overflow", fifo_overflow, 1'b0);
        check_value("dma_done_cnt", dma_done_cnt, 0);
        report_test("reset_state", err_before);
    endtask

    task automatic test_live_data();
        int err_before;
        err_before = err_cnt;
        configure(100, 8, WAIT_RANDOM);
        send_beat(mode_live, mode_live, mode_live);
        wait_writes(3);
        for (int g = 0; g < 3; g++)
            check_channel(g, 100, 8, 1);
        report_test("live_data", err_before);
    endtask

    task automatic test_test_modes();
        int err_before;
        err_before = err_cnt;
        set_mode(1, mode_ramp);
        set_mode(2, mode_pattern_a);
        set_mode(0, mode_pattern_b);
        configure(200, 8, WAIT_RANDOM);
        send_beat(mode_pattern_b, mode_ramp, mode_pattern_a);
        wait_writes(3);
        for (int g = 0; g < 3; g++)
            check_channel(g, 200, 8, 1);
        for (int g = 0; g < 3; g++)
            set_mode(g, mode_live);
        report_test("test_modes", err_before);
    endtask

    task automatic test_ring_wrap();
        int err_before;
        err_before = err_cnt;
        configure(300, 2, WAIT_RANDOM);
        repeat (3) send_beat(mode_live, mode_live, mode_live);
        wait_writes(9);
        for (int g = 0; g < 3; g++)
            check_channel(g, 300, 2, 3);    // indices 0, 1, 0
        check_value("dma_done_cnt", dma_done_cnt, 1);
        report_test("ring_wrap", err_before);
    endtask

    task automatic test_back_pressure();
        int err_before;
        err_before = err_cnt;
        configure(400, 8, WAIT_HIGH);
        repeat (FIFO_DEPTH) send_beat(mode_live, mode_live, mode_live);
        check_value("fifo_overflow", fifo_overflow, 1'b0);     // fifos just full
        repeat (6 - FIFO_DEPTH) send_beat(mode_live, mode_live, mode_live);
        check_value("fifo_overflow", fifo_overflow, 1'b1);
        wait_mode = WAIT_LOW;
        wait_writes(3 * FIFO_DEPTH);
        repeat (20) next_cycle();       // nothing more may follow
        check_value("accepted writes", accept_cnt, 3 * FIFO_DEPTH);
        for (int g = 0; g < 3; g++)
            check_channel(g, 400, 8, FIFO_DEPTH);
        check_value("fifo_overflow", fifo_overflow, 1'b1);
        report_test("back_pressure", err_before);
    endtask

    initial
    begin
        seed              = 32'h35f6;
        wait_mode         = WAIT_LOW;
        strobe_cnt        = 0;
        err_cnt           = 0;
        test_cnt          = 0;
        fail_cnt          = 0;
        accept_cnt        = 0;
        sw                = 4'b1100;
        adc_data_0        = '0;
        adc_data_1        = '0;
        adc_data_2        = '0;
        sample_strobe     = 1'b0;
        dma_on            = 1'b0;
        dma_start_address = '0;
        dma_buf_size      = '0;
        w_adc_rst         = 1'b1;
        repeat (RESET_CYCLES) @(posedge w_bus_clk);
        #2;
        w_adc_rst = 1'b0;
        next_cycle();

        test_reset_state();
        test_live_data();
        test_test_modes();
        test_ring_wrap();
        test_back_pressure();      // runs last since overflow is sticky

        $display("tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/scan_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_assert
(
    input wire                          w_bus_clk,
    input wire                          w_adc_rst,
    input wire                          sdram_write,
    input wire                          sdram_waitrequest,
    input wire scan_pkg::sdram_addr_t   sdram_address,
    input wire scan_pkg::beat_t         sdram_writedata,
    input wire                          fifo_overflow
);

    // a stalled write keeps its address and data
    held_write_stable : assert property (@(posedge w_bus_clk) disable iff (w_adc_rst)
        sdram_write && sdram_waitrequest |=> $stable(sdram_address) && $stable(sdram_writedata))
        else $error("sdram address or data changed while waitrequest held the write");

    overflow_sticky : assert property (@(posedge w_bus_clk) disable iff (w_adc_rst)
        !$fell(fifo_overflow))
        else $error("fifo_overflow fell without a reset");

    no_write_in_reset : assert property (@(posedge w_bus_clk)
        w_adc_rst |=> !sdram_write)     // outputs clean after a reset edge
        else $error("sdram_write high during reset");

endmodule

bind scan_top scan_assert scan_assert_i
(
    .w_bus_clk         ( w_bus_clk         ),
    .w_adc_rst         ( w_adc_rst         ),
    .sdram_write       ( sdram_write       ),
    .sdram_waitrequest ( sdram_waitrequest ),
    .sdram_address     ( sdram_address     ),
    .sdram_writedata   ( sdram_writedata   ),
    .fifo_overflow     ( fifo_overflow     )
);

`default_nettype wire

// ==== source/scan_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_top
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,
    input  wire [3:0]                   sw,
    input  wire scan_pkg::sample_t      adc_data_0,
    input  wire scan_pkg::sample_t      adc_data_1,
    input  wire scan_pkg::sample_t      adc_data_2,
    input  wire                         sample_strobe,
    input  wire                         dma_on,
    input  wire scan_pkg::sdram_addr_t  dma_start_address,
    input  wire scan_pkg::sdram_addr_t  dma_buf_size,
    input  wire                         sdram_waitrequest,
    output scan_pkg::beat_t             sdram_writedata,
    output scan_pkg::sdram_addr_t       sdram_address,
    output logic                        sdram_write,
    output logic                        fifo_overflow,
    output scan_pkg::done_cnt_t         dma_done_cnt
);

    import scan_pkg::*;

    sample_t        adc_data      [CHANNELS];
    test_mode_e     test_mode     [CHANNELS];
    sdram_addr_t    region_start  [CHANNELS];
    sdram_addr_t    buf_size_q;
    beat_t          beat          [CHANNELS];
    logic           beat_valid    [CHANNELS];
    logic           dma_write     [CHANNELS];
    sdram_addr_t    dma_address   [CHANNELS];
    beat_t          dma_writedata [CHANNELS];
    logic           dma_waitreq   [CHANNELS];
    logic           overflow      [CHANNELS];
    done_cnt_t      done_cnt      [CHANNELS];

    assign adc_data[0]  = adc_data_0;
    assign adc_data[1]  = adc_data_1;
    assign adc_data[2]  = adc_data_2;
    assign dma_done_cnt = done_cnt[0];      // status reports channel 0 only

    test_mode_select test_mode_select_i
    (
        .w_bus_clk   ( w_bus_clk    ),
        .w_adc_rst   ( w_adc_rst    ),
        .sw          ( sw           ),
        .test_mode_0 ( test_mode[0] ),
        .test_mode_1 ( test_mode[1] ),
        .test_mode_2 ( test_mode[2] )
    );

    dma_control dma_control_i
    (
        .w_bus_clk         ( w_bus_clk         ),
        .w_adc_rst         ( w_adc_rst         ),
        .dma_start_address ( dma_start_address ),
        .dma_buf_size      ( dma_buf_size      ),
        .overflow_0        ( overflow[0]       ),
        .overflow_1        ( overflow[1]       ),
        .overflow_2        ( overflow[2]       ),
        .region_start_0    ( region_start[0]   ),
        .region_start_1    ( region_start[1]   ),
        .region_start_2    ( region_start[2]   ),
        .buf_size_q        ( buf_size_q        ),
        .fifo_overflow     ( fifo_overflow     )
    );

    //////////////////////////////
    // per channel datapath

    for (genvar g = 0; g < CHANNELS; g++)
    begin : g_channel
        pixel_packer pixel_packer_i
        (
            .w_bus_clk     ( w_bus_clk     ),
            .w_adc_rst     ( w_adc_rst     ),
            .adc_data      ( adc_data[g]   ),
            .sample_strobe ( sample_strobe ),
            .test_mode     ( test_mode[g]  ),
            .beat          ( beat[g]       ),
            .beat_valid    ( beat_valid[g] )
        );

        channel_dma_writer #(.FIFO_DEPTH(FIFO_DEPTH)) channel_dma_writer_i
        (
            .w_bus_clk     ( w_bus_clk        ),
            .w_adc_rst     ( w_adc_rst        ),
            .beat          ( beat[g]          ),
            .beat_valid    ( beat_valid[g]    ),
            .dma_on        ( dma_on           ),
            .region_start  ( region_start[g]  ),
            .buf_size      ( buf_size_q       ),
            .dma_waitreq   ( dma_waitreq[g]   ),
            .dma_write     ( dma_write[g]     ),
            .dma_address   ( dma_address[g]   ),
            .dma_writedata ( dma_writedata[g] ),
            .overflow      ( overflow[g]      ),
            .done_cnt      ( done_cnt[g]      )
        );
    end

    sdram_write_arbiter sdram_write_arbiter_i
    (
        .w_bus_clk         ( w_bus_clk         ),
        .w_adc_rst         ( w_adc_rst         ),
        .dma_write_0       ( dma_write[0]      ),
        .dma_write_1       ( dma_write[1]      ),
        .dma_write_2       ( dma_write[2]      ),
        .dma_address_0     ( dma_address[0]    ),
        .dma_address_1     ( dma_address[1]    ),
        .dma_address_2     ( dma_address[2]    ),
        .dma_writedata_0   ( dma_writedata[0]  ),
        .dma_writedata_1   ( dma_writedata[1]  ),
        .dma_writedata_2   ( dma_writedata[2]  ),
        .sdram_waitrequest ( sdram_waitrequest ),
        .dma_waitreq_0     ( dma_waitreq[0]    ),
        .dma_waitreq_1     ( dma_waitreq[1]    ),
        .dma_waitreq_2     ( dma_waitreq[2]    ),
        .sdram_write       ( sdram_write       ),
        .sdram_address     ( sdram_address     ),
        .sdram_writedata   ( sdram_writedata   )
    );

endmodule

`default_nettype wire

// ==== source/sdram_write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_write_arbiter
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,
    input  wire                         dma_write_0,
    input  wire                         dma_write_1,
    input  wire                         dma_write_2,
    input  wire scan_pkg::sdram_addr_t  dma_address_0,
    input  wire scan_pkg::sdram_addr_t  dma_address_1,
    input  wire scan_pkg::sdram_addr_t  dma_address_2,
    input  wire scan_pkg::beat_t        dma_writedata_0,
    input  wire scan_pkg::beat_t        dma_writedata_1,
    input  wire scan_pkg::beat_t        dma_writedata_2,
    input  wire                         sdram_waitrequest,
    output logic                        dma_waitreq_0,
    output logic                        dma_waitreq_1,
    output logic                        dma_waitreq_2,
    output logic                        sdram_write,
    output scan_pkg::sdram_addr_t       sdram_address,
    output scan_pkg::beat_t             sdram_writedata
);

    import scan_pkg::*;

    localparam int GRANT_W = $clog2(CHANNELS);

    logic [GRANT_W-1:0]     grant;
    logic [GRANT_W-1:0]     grant_next;
    logic [CHANNELS-1:0]    req;
    logic                   accepted;

    assign req      = {dma_write_2, dma_write_1, dma_write_0};
    assign accepted = sdram_write && !sdram_waitrequest;

    //////////////////////////////
    // port mux

    always_comb
    begin
        case (grant)
            2'd1:
            begin
                sdram_write     = dma_write_1;
                sdram_address   = dma_address_1;
                sdram_writedata = dma_writedata_1;
            end
            2'd2:
            begin
                sdram_write     = dma_write_2;
                sdram_address   = dma_address_2;
                sdram_writedata = dma_writedata_2;
            end
            default:
            begin
                sdram_write     = dma_write_0;
                sdram_address   = dma_address_0;
                sdram_writedata = dma_writedata_0;
            end
        endcase
    end

    // losers always see waitrequest
    assign dma_waitreq_0 = (grant == 2'd0) ? sdram_waitrequest : 1'b1;
    assign dma_waitreq_1 = (grant == 2'd1) ? sdram_waitrequest : 1'b1;
    assign dma_waitreq_2 = (grant == 2'd2) ? sdram_waitrequest : 1'b1;

    //////////////////////////////
    // round robin

    always_comb
    begin
        int idx;
        grant_next = grant;
        // farthest first, so the nearest requester after grant wins
        for (int i = CHANNELS; i >= 1; i--)
        begin
            idx = int'(grant) + i;
            if (idx >= CHANNELS)
                idx = idx - CHANNELS;
            if (req[idx])
                grant_next = GRANT_W'(idx);
        end
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
            grant <= '0;
        else if (accepted || !req[grant])
            grant <= grant_next;        // idle grant moves on too
    end

endmodule

`default_nettype wire

// ==== source/dma_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_control
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,
    input  wire scan_pkg::sdram_addr_t  dma_start_address,
    input  wire scan_pkg::sdram_addr_t  dma_buf_size,
    input  wire                         overflow_0,
    input  wire                         overflow_1,
    input  wire                         overflow_2,
    output scan_pkg::sdram_addr_t       region_start_0,
    output scan_pkg::sdram_addr_t       region_start_1,
    output scan_pkg::sdram_addr_t       region_start_2,
    output scan_pkg::sdram_addr_t       buf_size_q,
    output logic                        fifo_overflow
);

    import scan_pkg::*;

    sdram_addr_t buf_size_x2;

    assign buf_size_x2 = dma_buf_size << 1;

    // regions sit back to back
    always_ff @(posedge w_bus_clk)
    begin
        region_start_0 <= dma_start_address;
        region_start_1 <= dma_start_address + dma_buf_size;
        region_start_2 <= dma_start_address + buf_size_x2;
        buf_size_q     <= dma_buf_size;
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
            fifo_overflow <= 1'b0;
        else if (overflow_0 || overflow_1 || overflow_2)
            fifo_overflow <= 1'b1;      // sticky until reset
    end

endmodule

`default_nettype wire

// ==== source/channel_dma_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_dma_writer
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,
    input  wire scan_pkg::beat_t        beat,
    input  wire                         beat_valid,
    input  wire                         dma_on,
    input  wire scan_pkg::sdram_addr_t  region_start,
    input  wire scan_pkg::sdram_addr_t  buf_size,
    input  wire                         dma_waitreq,
    output logic                        dma_write,
    output scan_pkg::sdram_addr_t       dma_address,
    output scan_pkg::beat_t             dma_writedata,
    output logic                        overflow,
    output scan_pkg::done_cnt_t         done_cnt
);

    import scan_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    beat_t              fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fill_cnt;
    sdram_addr_t        ring_idx;       // beat offset inside the region
    logic               fifo_full;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    assign fifo_full = (fill_cnt == CNT_W'(FIFO_DEPTH));
    assign push      = beat_valid && dma_on && !fifo_full;
    assign pop       = dma_write && !dma_waitreq;

    // fifo head goes straight to the arbiter
    assign dma_write     = (fill_cnt != '0);
    assign dma_address   = region_start + ring_idx;
    assign dma_writedata = fifo_mem[rd_ptr];

    //////////////////////////////
    // pointers, ring index, status

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            ring_idx <= '0;
            done_cnt <= '0;
            overflow <= 1'b0;
        end
        else if (!dma_on)
        begin
            wr_ptr   <= '0;     // flush, restart at region start
            rd_ptr   <= '0;
            fill_cnt <= '0;
            ring_idx <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            overflow <= beat_valid && fifo_full;    // beat lost
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
            begin
                rd_ptr <= ptr_next(rd_ptr);
                if (ring_idx >= buf_size - 1'b1)
                begin
                    ring_idx <= '0;
                    done_cnt <= done_cnt + 1'b1;
                end
                else
                    ring_idx <= ring_idx + 1'b1;
            end
            fill_cnt <= fill_cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= beat;
    end

endmodule

`default_nettype wire

// ==== source/pixel_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_packer
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,
    input  wire scan_pkg::sample_t      adc_data,
    input  wire                         sample_strobe,
    input  wire scan_pkg::test_mode_e   test_mode,
    output scan_pkg::beat_t             beat,
    output logic                        beat_valid
);

    import scan_pkg::*;

    localparam int LANE_IDX_W = $clog2(SAMPLES_PER_BEAT);

    sample_t                ramp_cnt;       // free running on strobes
    sample_t                src_sample;
    logic [LANE_IDX_W-1:0]  lane_idx;
    logic                   last_lane;

    assign last_lane = (lane_idx == LANE_IDX_W'(SAMPLES_PER_BEAT - 1));

    always_comb
    begin
        case (test_mode)
            mode_ramp:      src_sample = ramp_cnt;
            mode_pattern_a: src_sample = PATTERN_A;
            mode_pattern_b: src_sample = PATTERN_B;
            default:        src_sample = adc_data;
        endcase
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            ramp_cnt   <= '0;
            lane_idx   <= '0;
            beat_valid <= 1'b0;
        end
        else
        begin
            beat_valid <= sample_strobe && last_lane;   // beat complete
            if (sample_strobe)
            begin
                ramp_cnt <= ramp_cnt + 1'b1;
                lane_idx <= last_lane ? '0 : lane_idx + 1'b1;
            end
        end
    end

    // lane fill, zero extended
    always_ff @(posedge w_bus_clk)
    begin
        if (sample_strobe)
            beat[lane_idx*LANE_WIDTH +: LANE_WIDTH] <= LANE_WIDTH'(src_sample);
    end

endmodule

`default_nettype wire

// ==== source/test_mode_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module test_mode_select
(
    input  wire                     w_bus_clk,
    input  wire                     w_adc_rst,
    input  wire [3:0]               sw,
    output scan_pkg::test_mode_e    test_mode_0,
    output scan_pkg::test_mode_e    test_mode_1,
    output scan_pkg::test_mode_e    test_mode_2
);

    import scan_pkg::*;

    logic [3:0] sw_q;   // registered switches

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            sw_q        <= 4'b1100;     // hold code
            test_mode_0 <= mode_live;
            test_mode_1 <= mode_live;
            test_mode_2 <= mode_live;
        end
        else
        begin
            sw_q <= sw;
            case (sw_q[3:2])
                2'd0:    test_mode_0 <= test_mode_e'(sw_q[1:0]);
                2'd1:    test_mode_1 <= test_mode_e'(sw_q[1:0]);
                2'd2:    test_mode_2 <= test_mode_e'(sw_q[1:0]);
                default: ;                                  // all modes keep
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/scan_pkg.sv ====
`default_nettype none

package scan_pkg;

    localparam int CHANNELS         = 3;     // r, g, b sensor lines
    localparam int SAMPLES_PER_BEAT = 8;
    localparam int LANE_WIDTH       = 16;

    typedef logic [11:0]                                sample_t;       // one adc sample
    typedef logic [SAMPLES_PER_BEAT*LANE_WIDTH-1:0]     beat_t;         // lane 0 = first sample
    typedef logic [27:0]                                sdram_addr_t;   // in 16-byte beats
    typedef logic [15:0]                                done_cnt_t;     // ring wraps

    // sample source per channel
    typedef enum logic [1:0]
    {
        mode_live      = 2'd0,
        mode_ramp      = 2'd1,
        mode_pattern_a = 2'd2,
        mode_pattern_b = 2'd3
    } test_mode_e;

    localparam sample_t PATTERN_A = 12'hAAA;
    localparam sample_t PATTERN_B = 12'h555;

endpackage

`default_nettype wire
